//--- common/gvp_prog_pkg.sv
package gvp_prog_pkg;

    ////////////////////
    // program geometry

    localparam int MAX_VECTORS_N2 = 6;                  // deepest program supported
    localparam int NEXT_W         = MAX_VECTORS_N2 + 1; // signed jump, index plus sign
    localparam int WORD_W         = 32;
    localparam int VP_SET_W       = 512;                // full write word, 16 words

    // word positions inside vp_set
    localparam int WORD_ADDR = 0;   // target entry index
    localparam int WORD_N    = 1;   // points in section, 0 ends program
    localparam int WORD_IIN  = 2;   // intermediate steps between points
    localparam int WORD_OPT  = 3;
    localparam int WORD_NREP = 4;   // extra passes through loop
    localparam int WORD_NEXT = 5;   // relative jump taken while repeating
    localparam int WORD_DX   = 6;
    localparam int WORD_DY   = 7;
    localparam int WORD_DZ   = 8;
    localparam int WORD_DU   = 9;
    localparam int WORD_DECI = 15;  // step divider

    typedef struct packed {
        logic        [WORD_W-1:0] n;
        logic        [WORD_W-1:0] iin;
        logic        [WORD_W-1:0] options;
        logic        [WORD_W-1:0] nrep;
        logic signed [NEXT_W-1:0] next;
        logic        [WORD_W-1:0] deci;
        logic signed [WORD_W-1:0] dx;
        logic signed [WORD_W-1:0] dy;
        logic signed [WORD_W-1:0] dz;
        logic signed [WORD_W-1:0] du;
    } vec_entry_t;

    // pick one 32 bit word out of the write word
    function automatic logic [WORD_W-1:0] vp_word(input logic [VP_SET_W-1:0] v,
                                                  input int unsigned idx);
        return v[idx*WORD_W +: WORD_W];
    endfunction

endpackage

//--- common/gvp_out_pkg.sv
package gvp_out_pkg;

    ////////////////////
    // output side

    localparam int TIME_W   = 48;   // run timer
    localparam int POS_W    = 32;   // position accumulators
    localparam int STATUS_W = 32;

    // store trigger codes on store_data
    typedef enum logic [1:0] {
        STORE_NONE   = 2'd0,
        STORE_POINT  = 2'd1,    // data point reached
        STORE_HEADER = 2'd2,    // section start, full vector header
        STORE_END    = 2'd3     // program end mark
    } store_t;

    // options word shown once the program has ended
    localparam logic [31:0] OPT_END = 32'hffff_ffff;

    // dbg_status layout
    localparam int DBG_NFIN  = 0;   // not finished
    localparam int DBG_HOLD  = 1;   // pause or stall
    localparam int DBG_RESET = 2;
    localparam int DBG_SEC   = 3;   // section count from here up

endpackage

//--- common/gvp_vector_if.sv
interface gvp_vector_if #(
    parameter int NUM_VECTORS_N2 = 4
);
    import gvp_prog_pkg::*;

    logic [NUM_VECTORS_N2-1:0] pvc;         // program counter
    vec_entry_t                cur;         // entry at pvc
    logic [WORD_W-1:0]         loop_left;   // repeats left for entry at pvc
    logic                      loop_take;   // one more pass, decrement
    logic                      loop_reload; // loop done, rearm counter

    modport store (
        input  pvc,
        input  loop_take,
        input  loop_reload,
        output cur,
        output loop_left
    );

    modport seq (
        output pvc,
        output loop_take,
        output loop_reload,
        input  cur,
        input  loop_left
    );

    // positions only need the deltas
    modport acc (
        input  cur
    );

endinterface

//--- program/gvp_program_store.sv
module gvp_program_store #(
    parameter int NUM_VECTORS_N2 = 4
)(
    input  logic                               a_clk,
    input  logic                               reset_flg,
    input  logic                               setvec,     // write strobe
    input  logic [gvp_prog_pkg::VP_SET_W-1:0]  vp_set,     // full entry plus address
    gvp_vector_if.store                        vif
);
    import gvp_prog_pkg::*;

    localparam int NUM_VECTORS = 1 << NUM_VECTORS_N2;

    logic                      setvec_q;                 // write lands one cycle late
    logic [VP_SET_W-1:0]       vp_q;
    logic [NUM_VECTORS_N2-1:0] wr_addr;
    vec_entry_t                wr_entry;
    vec_entry_t                mem      [NUM_VECTORS];   // program list
    logic [WORD_W-1:0]         loop_cnt [NUM_VECTORS];   // repeats left per entry

    ////////////////////
    // unpack write word

    always_comb
    begin
        wr_addr          = NUM_VECTORS_N2'(vp_word(vp_q, WORD_ADDR)); // low bits only
        wr_entry.n       = vp_word(vp_q, WORD_N);
        wr_entry.iin     = vp_word(vp_q, WORD_IIN);
        wr_entry.options = vp_word(vp_q, WORD_OPT);
        wr_entry.nrep    = vp_word(vp_q, WORD_NREP);
        wr_entry.next    = NEXT_W'(vp_word(vp_q, WORD_NEXT)); // keeps sign in low bits
        wr_entry.deci    = vp_word(vp_q, WORD_DECI);
        wr_entry.dx      = vp_word(vp_q, WORD_DX);
        wr_entry.dy      = vp_word(vp_q, WORD_DY);
        wr_entry.dz      = vp_word(vp_q, WORD_DZ);
        wr_entry.du      = vp_word(vp_q, WORD_DU);
    end

    always_ff @(posedge a_clk)
    begin
        setvec_q <= setvec;
        vp_q     <= vp_set;
        if (setvec_q)
            mem[wr_addr] <= wr_entry;
    end

    ////////////////////
    // loop counters

    always_ff @(posedge a_clk)
    begin
        if (reset_flg)
        begin
            for (int k = 0; k < NUM_VECTORS; k++)
                loop_cnt[k] <= mem[k].nrep;             // rearm every loop for next run
        end
        else if (vif.loop_take)
            loop_cnt[vif.pvc] <= vif.loop_left - 1'b1;  // one pass used
        else if (vif.loop_reload)
            loop_cnt[vif.pvc] <= vif.cur.nrep;          // loop left, ready for next time
        if (setvec_q)
            loop_cnt[wr_addr] <= wr_entry.nrep;         // fresh entry wins
    end

    assign vif.cur       = mem[vif.pvc];                // read is combinational
    assign vif.loop_left = loop_cnt[vif.pvc];

endmodule

//--- program/gvp_sequencer.sv
module gvp_sequencer #(
    parameter int NUM_VECTORS_N2 = 4
)(
    input  logic                 a_clk,
    input  logic                 reset_flg,
    input  logic                 pause,
    input  logic                 stall,
    gvp_vector_if.seq            vif,
    output logic                 step,        // add deltas this cycle
    output logic                 clear,       // zero positions at program start
    output logic                 finished,
    output logic                 running,
    output gvp_out_pkg::store_t  store_code,
    output logic [31:0]          index,       // points left in section
    output logic [31:0]          sec          // sections completed
);
    import gvp_out_pkg::*;

    logic [31:0]               div;            // decimation down counter
    logic [31:0]               i;              // points left
    logic [31:0]               ii;             // intermediate steps left
    logic [NUM_VECTORS_N2-1:0] pvc;
    logic                      load_pending;   // next action reads a new entry
    logic                      hold;
    logic                      tick;
    logic                      act;
    logic                      load_tick;
    logic                      step_tick;
    logic                      sec_end;

    ////////////////////
    // action decode

    assign hold      = pause | stall;                   // stall acts like pause
    assign tick      = (div == '0);
    assign act       = tick & ~hold & ~finished;
    assign load_tick = act & load_pending;
    assign step_tick = act & ~load_pending & running;
    assign sec_end   = step_tick & (ii == '0) & (i == '0);

    assign step            = step_tick;
    assign clear           = load_tick & ~running;     // only the very first load
    assign vif.loop_take   = sec_end & (vif.loop_left != '0);
    assign vif.loop_reload = sec_end & (vif.loop_left == '0);
    assign vif.pvc         = pvc;
    assign index           = i;

    ////////////////////
    // program flow

    always_ff @(posedge a_clk)
    begin
        if (reset_flg)
        begin
            div          <= '0;                     // first tick right after reset
            i            <= '0;
            ii           <= '0;
            pvc          <= '0;
            sec          <= '0;
            load_pending <= 1'b1;
            finished     <= 1'b0;
            running      <= 1'b0;
            store_code   <= STORE_NONE;
        end
        else
        begin
            store_code <= STORE_NONE;               // triggers are single cycle
            if (tick)
                div <= finished ? '0 : vif.cur.deci;
            else
                div <= div - 1'b1;

            if (load_tick)
            begin
                load_pending <= 1'b0;
                if (vif.cur.n == '0)
                begin
                    finished   <= 1'b1;             // held until reset
                    running    <= 1'b0;
                    store_code <= STORE_END;
                end
                else
                begin
                    running    <= 1'b1;
                    store_code <= STORE_HEADER;
                    i          <= vif.cur.n;
                    ii         <= vif.cur.iin;
                end
            end
            else if (step_tick)
            begin
                if (ii != '0)
                    ii <= ii - 1'b1;                // intermediate step
                else if (i != '0)
                begin
                    store_code <= STORE_POINT;      // data point reached
                    i          <= i - 1'b1;
                    ii         <= vif.cur.iin;
                end
                else
                begin
                    sec          <= sec + 1'b1;     // section done
                    load_pending <= 1'b1;
                    if (vif.loop_take)
                        pvc <= pvc + NUM_VECTORS_N2'(vif.cur.next); // back to loop head
                    else
                        pvc <= pvc + 1'b1;
                end
            end
        end
    end

endmodule

//--- logic/gvp_accumulator.sv
module gvp_accumulator (
    input  logic                                a_clk,
    input  logic                                reset_flg,
    input  logic                                step,    // one add per strobe
    input  logic                                clear,
    gvp_vector_if.acc                           vif,
    output logic signed [gvp_out_pkg::POS_W-1:0] x,
    output logic signed [gvp_out_pkg::POS_W-1:0] y,
    output logic signed [gvp_out_pkg::POS_W-1:0] z,
    output logic signed [gvp_out_pkg::POS_W-1:0] u
);

    ////////////////////
    // position sums

    always_ff @(posedge a_clk)
    begin
        if (reset_flg || clear)
        begin
            x <= '0;
            y <= '0;
            z <= '0;
            u <= '0;
        end
        else if (step)
        begin
            x <= x + vif.cur.dx;            // wraps at 32 bits
            y <= y + vif.cur.dy;
            z <= z + vif.cur.dz;
            u <= u + vif.cur.du;
        end
    end

endmodule

//--- logic/gvp_output_stage.sv
module gvp_output_stage (
    input  logic                                    a_clk,
    input  logic                                    reset_flg,
    input  logic                                    finished,
    input  logic                                    running,
    input  gvp_out_pkg::store_t                     store_code,
    input  logic [31:0]                             index,
    input  logic [31:0]                             sec,
    input  logic signed [gvp_out_pkg::POS_W-1:0]    x,
    input  logic signed [gvp_out_pkg::POS_W-1:0]    y,
    input  logic signed [gvp_out_pkg::POS_W-1:0]    z,
    input  logic signed [gvp_out_pkg::POS_W-1:0]    u,
    input  logic [31:0]                             cur_options,
    input  logic [31:0]                             reset_options,  // idle options
    input  logic                                    pause,
    input  logic                                    stall,
    output logic [gvp_out_pkg::POS_W-1:0]           pos_x,
    output logic [gvp_out_pkg::POS_W-1:0]           pos_y,
    output logic [gvp_out_pkg::POS_W-1:0]           pos_z,
    output logic [gvp_out_pkg::POS_W-1:0]           pos_u,
    output logic [31:0]                             options,
    output logic [31:0]                             index_out,
    output logic [1:0]                              store_data,
    output logic                                    gvp_finished,
    output logic                                    gvp_hold,
    output logic [gvp_out_pkg::TIME_W-1:0]          gvp_time,
    output logic [gvp_out_pkg::STATUS_W-1:0]        dbg_status
);
    import gvp_out_pkg::*;

    logic hold;

    assign hold = pause | stall;

    always_ff @(posedge a_clk)
    begin
        pos_x     <= x;
        pos_y     <= y;
        pos_z     <= z;
        pos_u     <= u;
        index_out <= index;
        gvp_hold  <= hold;

        dbg_status[STATUS_W-1:DBG_SEC] <= sec[STATUS_W-DBG_SEC-1:0];
        dbg_status[DBG_RESET]          <= reset_flg;
        dbg_status[DBG_HOLD]           <= hold;
        dbg_status[DBG_NFIN]           <= ~finished;

        if (reset_flg)
        begin
            options      <= reset_options;
            store_data   <= STORE_NONE;
            gvp_finished <= 1'b0;
            gvp_time     <= '0;
        end
        else
        begin
            if (running)
                options <= cur_options;     // active section
            else if (finished)
                options <= OPT_END;         // sticks until reset
            store_data   <= store_code;
            gvp_finished <= finished;
            gvp_time     <= gvp_time + 1'b1;   // a_clk cycles since reset
        end
    end

endmodule

//--- logic/gvp_core.sv
module gvp_core #(
    parameter int NUM_VECTORS_N2 = 4                  // program depth 2**n
)(
    input  logic                                a_clk,
    input  logic                                reset_flg,
    input  logic                                pause,
    input  logic                                stall,
    input  logic                                setvec,
    input  logic [gvp_prog_pkg::VP_SET_W-1:0]   vp_set,
    input  logic [31:0]                         reset_options,
    output logic [gvp_out_pkg::POS_W-1:0]       pos_x,
    output logic [gvp_out_pkg::POS_W-1:0]       pos_y,
    output logic [gvp_out_pkg::POS_W-1:0]       pos_z,
    output logic [gvp_out_pkg::POS_W-1:0]       pos_u,
    output logic [31:0]                         options,
    output logic [31:0]                         index_out,
    output logic [1:0]                          store_data,
    output logic                                gvp_finished,
    output logic                                gvp_hold,
    output logic [gvp_out_pkg::TIME_W-1:0]      gvp_time,
    output logic [gvp_out_pkg::STATUS_W-1:0]    dbg_status
);
    import gvp_out_pkg::*;

    logic                     step;
    logic                     clear;
    logic                     finished;
    logic                     running;
    store_t                   store_code;
    logic [31:0]              index;
    logic [31:0]              sec;
    logic signed [POS_W-1:0]  x;
    logic signed [POS_W-1:0]  y;
    logic signed [POS_W-1:0]  z;
    logic signed [POS_W-1:0]  u;

    gvp_vector_if #(.NUM_VECTORS_N2(NUM_VECTORS_N2)) vif ();

    gvp_program_store #(.NUM_VECTORS_N2(NUM_VECTORS_N2)) store0 (
        .a_clk(a_clk), .reset_flg(reset_flg), .setvec(setvec), .vp_set(vp_set), .vif(vif)
    );

    gvp_sequencer #(.NUM_VECTORS_N2(NUM_VECTORS_N2)) seq0 (
        .a_clk(a_clk), .reset_flg(reset_flg), .pause(pause), .stall(stall), .vif(vif),
        .step(step), .clear(clear), .finished(finished), .running(running),
        .store_code(store_code), .index(index), .sec(sec)
    );

    gvp_accumulator acc0 (
        .a_clk(a_clk), .reset_flg(reset_flg), .step(step), .clear(clear), .vif(vif),
        .x(x), .y(y), .z(z), .u(u)
    );

    gvp_output_stage out0 (
        .a_clk(a_clk), .reset_flg(reset_flg), .finished(finished), .running(running),
        .store_code(store_code), .index(index), .sec(sec),
        .x(x), .y(y), .z(z), .u(u),
        .cur_options(vif.cur.options), .reset_options(reset_options),
        .pause(pause), .stall(stall),
        .pos_x(pos_x), .pos_y(pos_y), .pos_z(pos_z), .pos_u(pos_u),
        .options(options), .index_out(index_out), .store_data(store_data),
        .gvp_finished(gvp_finished), .gvp_hold(gvp_hold), .gvp_time(gvp_time),
        .dbg_status(dbg_status)
    );

endmodule

//--- testbench/gvp_tb_table.svh
`ifndef GVP_TB_TABLE_SVH
`define GVP_TB_TABLE_SVH

////////////////////
// test programs

localparam int NUM_ROWS = 4;
localparam int MAX_ENTS = 6;

string       row_name    [NUM_ROWS];
int          row_count   [NUM_ROWS];            // entries written, last one has n = 0
vec_entry_t  row_ent     [NUM_ROWS][MAX_ENTS];
logic [31:0] row_ropt    [NUM_ROWS];            // reset_options while idle
int          row_pause   [NUM_ROWS];            // hold chance per cycle, percent
int          row_exp_sec [NUM_ROWS];            // sections by hand
int          row_exp_pts [NUM_ROWS];            // point triggers by hand

task automatic set_row(input int r, input string name, input int count,
                       input logic [31:0] ropt, input int pct, input int sec, input int pts);
    row_name[r]    = name;
    row_count[r]   = count;
    row_ropt[r]    = ropt;
    row_pause[r]   = pct;
    row_exp_sec[r] = sec;
    row_exp_pts[r] = pts;
endtask

task automatic set_entry(input int r, input int k, input int n, input int iin,
                         input int nrep, input int next, input int deci,
                         input int dx, input int dy, input int dz, input int du);
    vec_entry_t e;
    e.n       = n;
    e.iin     = iin;
    e.options = 32'hc000_0000 | (r << 8) | k;   // tagged per row and entry
    e.nrep    = nrep;
    e.next    = NEXT_W'(next);
    e.deci    = deci;
    e.dx      = dx;
    e.dy      = dy;
    e.dz      = dz;
    e.du      = du;
    row_ent[r][k] = e;
endtask

task automatic fill_table();
    //      row  name            ents  reset_options  pause  sec  pts
    set_row(0,   "single",       2,    32'h0000_00a5, 0,     1,   3);
    set_row(1,   "two_sec_deci", 3,    32'h1234_5678, 0,     2,   3);
    set_row(2,   "inner_loop",   4,    32'h0000_0001, 10,    7,   10);
    set_row(3,   "pause_loop",   3,    32'h8000_0000, 20,    4,   6);
    //        row ent  n  iin nrep next deci  dx   dy            dz    du
    set_entry(0,  0,   3, 1,  0,   0,   0,    5,   -2,           100,  0);
    set_entry(0,  1,   0, 0,  0,   0,   0,    0,   0,            0,    0);
    set_entry(1,  0,   2, 0,  0,   0,   2,    1,   2,            3,    4);
    set_entry(1,  1,   1, 3,  0,   0,   1,    -7,  32'h7fff_ffff, 0,   -1);  // dy wraps
    set_entry(1,  2,   0, 0,  0,   0,   0,    0,   0,            0,    0);
    set_entry(2,  0,   1, 1,  0,   0,   0,    10,  0,            0,    0);
    set_entry(2,  1,   2, 0,  0,   0,   0,    -3,  1,            0,    0);
    set_entry(2,  2,   1, 0,  2,   -1,  0,    0,   0,            7,    0);   // back to 1, 3 passes
    set_entry(2,  3,   0, 0,  0,   0,   0,    0,   0,            0,    0);
    set_entry(3,  0,   2, 2,  0,   0,   3,    3,   -5,           0,    0);
    set_entry(3,  1,   1, 0,  1,   -1,  1,    0,   0,            -11,  9);   // back to 0, 2 passes
    set_entry(3,  2,   0, 0,  0,   0,   0,    0,   0,            0,    0);
endtask

`endif

//--- testbench/gvp_tb.sv
module gvp_tb;
    import gvp_prog_pkg::*;
    import gvp_out_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int DRIVE_DLY  = 2;      // inputs change this long after the rising edge
    localparam int RESET_CYC  = 4;
    localparam int TAIL_CYC   = 4;      // cycles watched after finish
    localparam int MARGIN_CYC = 200;

    logic                  a_clk;
    logic                  reset_flg;
    logic                  pause;
    logic                  stall;
    logic                  setvec;
    logic [VP_SET_W-1:0]   vp_set;
    logic [31:0]           reset_options;
    logic [POS_W-1:0]      pos_x;
    logic [POS_W-1:0]      pos_y;
    logic [POS_W-1:0]      pos_z;
    logic [POS_W-1:0]      pos_u;
    logic [31:0]           options;
    logic [31:0]           index_out;
    logic [1:0]            store_data;
    logic                  gvp_finished;
    logic                  gvp_hold;
    logic [TIME_W-1:0]     gvp_time;
    logic [STATUS_W-1:0]   dbg_status;

    int                n_checks = 0;
    int                n_errors = 0;
    int                cnt_point;
    int                cnt_header;
    int                cnt_end;
    int                cur_row;
    logic [31:0]       pts_left;        // points still due in the current section
    logic              last_hold;       // hold driven in the previous cycle
    logic [TIME_W-1:0] last_time;
    string             cur_name;
    longint            budget = 0;      // watchdog time, set once
    logic [31:0]       m_x;
    logic [31:0]       m_y;
    logic [31:0]       m_z;
    logic [31:0]       m_u;
    longint            m_steps;
    int                m_sec;
    int                m_pts;
    int                m_max_deci;
    int                m_sec_ent [$];   // entry index of each executed section
    int unsigned       seed_val;

    `include "gvp_tb_table.svh"

    gvp_core #(.NUM_VECTORS_N2(4)) dut0 (
        .a_clk(a_clk), .reset_flg(reset_flg), .pause(pause), .stall(stall),
        .setvec(setvec), .vp_set(vp_set), .reset_options(reset_options),
        .pos_x(pos_x), .pos_y(pos_y), .pos_z(pos_z), .pos_u(pos_u),
        .options(options), .index_out(index_out), .store_data(store_data),
        .gvp_finished(gvp_finished), .gvp_hold(gvp_hold), .gvp_time(gvp_time),
        .dbg_status(dbg_status)
    );

    always #(CLK_PERIOD / 2) a_clk = ~a_clk;

    task automatic compare_value(input string what, input logic [63:0] expected,
                                 input logic [63:0] actual);
        n_checks++;
        if (expected !== actual)
        begin
            n_errors++;
            $display("Mismatch %s: expected %0h, actual %0h", what, expected, actual);
        end
    endtask

    // one entry into the 512 bit write word
    function automatic logic [VP_SET_W-1:0] pack_entry(input int addr, input vec_entry_t e);
        logic [VP_SET_W-1:0] w;
        w = '0;
        w[WORD_ADDR*WORD_W +: WORD_W] = addr;
        w[WORD_N*WORD_W    +: WORD_W] = e.n;
        w[WORD_IIN*WORD_W  +: WORD_W] = e.iin;
        w[WORD_OPT*WORD_W  +: WORD_W] = e.options;
        w[WORD_NREP*WORD_W +: WORD_W] = e.nrep;
        w[WORD_NEXT*WORD_W +: WORD_W] = WORD_W'(e.next);    // sign extended jump
        w[WORD_DECI*WORD_W +: WORD_W] = e.deci;
        w[WORD_DX*WORD_W   +: WORD_W] = e.dx;
        w[WORD_DY*WORD_W   +: WORD_W] = e.dy;
        w[WORD_DZ*WORD_W   +: WORD_W] = e.dz;
        w[WORD_DU*WORD_W   +: WORD_W] = e.du;
        return w;
    endfunction

    ////////////////////
    // reference model

    task automatic model_row(input int r);
        logic [31:0] left [MAX_ENTS];   // repeats left per entry
        vec_entry_t  e;
        longint      ss;                // steps in this section
        int          pc;
        int          guard;
        for (int k = 0; k < row_count[r]; k++)
            left[k] = row_ent[r][k].nrep;
        {m_x, m_y, m_z, m_u} = '0;
        m_steps    = 0;
        m_sec      = 0;
        m_pts      = 0;
        m_max_deci = 0;
        m_sec_ent.delete();
        pc         = 0;
        guard      = 0;
        while (pc >= 0 && pc < row_count[r] && guard < 1000)
        begin
            e = row_ent[r][pc];
            if (e.deci > m_max_deci)
                m_max_deci = e.deci;
            if (e.n == 0)
                break;                                  // end of program
            ss      = (longint'(e.n) + 1) * (longint'(e.iin) + 1);
            m_steps += ss;
            m_sec++;
            m_sec_ent.push_back(pc);
            m_pts   += e.n;
            m_x     = m_x + 32'(ss * longint'(e.dx));   // wraps at 32 bits
            m_y     = m_y + 32'(ss * longint'(e.dy));
            m_z     = m_z + 32'(ss * longint'(e.dz));
            m_u     = m_u + 32'(ss * longint'(e.du));
            if (left[pc] > 0)
            begin
                left[pc] = left[pc] - 1;
                pc       = pc + e.next;                 // another pass
            end
            else
            begin
                left[pc] = e.nrep;
                pc       = pc + 1;
            end
            guard++;
        end
    endtask

    // one clock, sample outputs then drive the next hold
    task automatic cycle_sample(input int pct);
        logic        h;
        int unsigned sel;
        vec_entry_t  e;
        @(posedge a_clk);
        #DRIVE_DLY;
        compare_value({cur_name, " gvp_hold"}, last_hold, gvp_hold);
        compare_value({cur_name, " dbg_status hold"}, last_hold, dbg_status[DBG_HOLD]);
        compare_value({cur_name, " gvp_time"}, last_time + 1'b1, gvp_time);
        last_time = gvp_time;
        case (store_data)
            STORE_POINT:
            begin
                cnt_point++;
                pts_left = pts_left - 1'b1;             // index shows points still due
                compare_value({cur_name, " point index_out"}, pts_left, index_out);
            end
            STORE_HEADER:
            begin
                if (cnt_header < m_sec_ent.size())
                begin
                    e        = row_ent[cur_row][m_sec_ent[cnt_header]];
                    pts_left = e.n;
                    compare_value({cur_name, " header index_out"}, e.n, index_out);
                    compare_value({cur_name, " header options"}, e.options, options);
                end
                cnt_header++;
            end
            STORE_END:    cnt_end++;
            default:      ;
        endcase
        h         = (pct > 0) && (($urandom % 100) < pct);
        sel       = $urandom;
        pause     = h & sel[0];                 // pause or stall, both hold
        stall     = h & ~sel[0];
        last_hold = h;
    endtask

    task automatic run_row(input int r, input bit load);
        cur_name   = load ? row_name[r] : {row_name[r], " rerun"};
        cur_row    = r;
        cnt_point  = 0;
        cnt_header = 0;
        cnt_end    = 0;
        pts_left   = '0;
        model_row(r);
        @(posedge a_clk);
        #DRIVE_DLY;
        reset_flg     = 1'b1;
        pause         = 1'b0;
        stall         = 1'b0;
        reset_options = row_ropt[r];
        if (load)
        begin
            for (int k = 0; k < row_count[r]; k++)
            begin
                setvec = 1'b1;
                vp_set = pack_entry(k, row_ent[r][k]);
                @(posedge a_clk);
                #DRIVE_DLY;
            end
            setvec = 1'b0;
        end
        repeat (RESET_CYC) @(posedge a_clk);
        #DRIVE_DLY;
        compare_value({cur_name, " reset options"}, row_ropt[r], options);
        compare_value({cur_name, " reset gvp_time"}, 0, gvp_time);
        compare_value({cur_name, " reset gvp_finished"}, 0, gvp_finished);
        compare_value({cur_name, " reset index_out"}, 0, index_out);
        compare_value({cur_name, " reset dbg_status"},
                      (1 << DBG_RESET) | (1 << DBG_NFIN), dbg_status);
        reset_flg = 1'b0;
        last_time = '0;
        last_hold = 1'b0;
        while (gvp_finished !== 1'b1)
            cycle_sample(row_pause[r]);                 // watchdog guards this
        repeat (TAIL_CYC) cycle_sample(0);
        compare_value({cur_name, " table sections"}, row_exp_sec[r], m_sec);
        compare_value({cur_name, " table points"}, row_exp_pts[r], m_pts);
        compare_value({cur_name, " headers"}, m_sec, cnt_header);
        compare_value({cur_name, " points"}, m_pts, cnt_point);
        compare_value({cur_name, " end marks"}, 1, cnt_end);
        compare_value({cur_name, " pos_x"}, m_x, pos_x);
        compare_value({cur_name, " pos_y"}, m_y, pos_y);
        compare_value({cur_name, " pos_z"}, m_z, pos_z);
        compare_value({cur_name, " pos_u"}, m_u, pos_u);
        compare_value({cur_name, " end options"}, OPT_END, options);
        compare_value({cur_name, " end index_out"}, 0, index_out);
        compare_value({cur_name, " end dbg_status"}, m_sec << DBG_SEC, dbg_status);
        compare_value({cur_name, " finished held"}, 1, gvp_finished);
    endtask

    ////////////////////
    // main sequence

    initial
    begin
        longint total;
        a_clk         = 1'b0;
        reset_flg     = 1'b1;
        pause         = 1'b0;
        stall         = 1'b0;
        setvec        = 1'b0;
        vp_set        = '0;
        reset_options = '0;
        seed_val      = $urandom(32'hf0918d2c);         // the only seeding
        fill_table();
        total = MARGIN_CYC;
        for (int r = 0; r < NUM_ROWS; r++)
        begin
            model_row(r);
            // two runs per row, each action at most deci+2 cycles apart
            total += 2 * ((m_steps + m_sec + 1) * (m_max_deci + 2) + row_count[r] + 20);
        end
        budget = total * CLK_PERIOD;
        repeat (RESET_CYC) @(posedge a_clk);
        for (int r = 0; r < NUM_ROWS; r++)
        begin
            run_row(r, 1'b1);
            run_row(r, 1'b0);                           // loop counters must rearm
        end
        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

    // watchdog
    initial
    begin
        wait (budget > 0);
        #(budget);
        $display("timeout: program did not finish within %0d time units", budget);
        $display("Something failed");
        $finish;
    end

endmodule

//--- sources.f
+incdir+testbench
common/gvp_prog_pkg.sv
common/gvp_out_pkg.sv
common/gvp_vector_if.sv
program/gvp_program_store.sv
program/gvp_sequencer.sv
logic/gvp_accumulator.sv
logic/gvp_output_stage.sv
logic/gvp_core.sv
testbench/gvp_tb.sv
